/* build.f */
+incdir+test
logic/inst_pkg.sv
logic/pipe_pkg.sv
logic/pipe_ctrl.sv
logic/fetch_queue.sv
logic/stage_reg.sv
logic/pipe_top.sv
test/tb_pipe_top.sv

/* Makefile */
TOOL     := verilator
TOP      := tb_pipe_top
FILELIST := build.f
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS     := *** TEST PASSED ***
SRCS     := $(wildcard logic/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run check clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q -F '$(PASS)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

check:
	@grep -q -F '$(PASS)' $(LOG) || (echo "no passing run in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_pipe_model.svh */
`ifndef tb_pipe_model_svh
`define tb_pipe_model_svh

// reference model of the queue and the six boundary registers.
// index 0 is ii_id2 and index 5 is the wb register.
inst_token_t m_queue[$];
inst_token_t m_stage[6];
logic        m_stall[6];
logic        m_flush[6];
logic        m_exp[6];
logic        m_pc_stall;
logic        m_fifo_flush;
logic        m_issue_stall;

task automatic model_reset();
    m_queue.delete();
    for (int i = 0; i < 6; i++) begin
        m_stage[i] = '0;
    end
endtask

// controller levels for the current inputs and model state.
task automatic model_comb();
    logic exc_any;
    logic cache;
    logic fwd;
    logic front;
    exc_any = req.exception_flush | req.mem_refetch;
    cache   = req.i_cache_stall_req | req.d_cache_stall_req;
    fwd     = (req.forwardc_req | req.forwardp_req) & ~req.b_ctrl_flush_req;
    front   = cache | fwd | req.exc_stall_req | req.lsu1_tlb_stall_req;
    m_pc_stall    = (m_queue.size() == queue_depth);
    m_fifo_flush  = req.b_ctrl_flush_req | exc_any;
    m_issue_stall = front;
    m_stall[0] = front | (m_pc_stall & m_fifo_flush);
    m_stall[1] = cache | req.exc_stall_req | req.lsu1_tlb_stall_req;
    m_stall[2] = cache | req.exc_stall_req;
    m_stall[3] = cache | req.exc_stall_req;
    m_stall[4] = cache | (req.exc_stall_req & ~exc_any);
    m_stall[5] = m_stall[4];
    m_flush[0] = req.b_ctrl_flush_req;
    m_flush[1] = (req.b_ctrl_flush_req & req.with_delay_slot) | req.forwardc_req
               | req.forwardp_req;
    m_flush[2] = req.lsu1_tlb_stall_req;
    m_flush[3] = 1'b0;
    m_flush[4] = 1'b0;
    m_flush[5] = 1'b0;
    for (int i = 0; i < 6; i++) begin
        m_exp[i] = (i < 4) ? exc_any : 1'b0;
    end
endtask

// one clock edge; stages go back to front so each reads the old upstream.
task automatic model_clock();
    inst_token_t head;
    inst_token_t fetched;
    logic        push_ok;
    head    = '0;
    fetched = '{valid: 1'b1, opcode: fetch_opcode, pc: fetch_pc};
    push_ok = fetch_valid & ~m_pc_stall;
    if (m_queue.size() > 0) begin
        head = m_queue[0];
    end
    for (int i = 5; i >= 0; i--) begin
        if (m_exp[i] || m_flush[i]) begin
            m_stage[i].valid = 1'b0;
        end else if (!m_stall[i]) begin
            if (i == 0) begin
                m_stage[i] = head;
            end else begin
                m_stage[i] = m_stage[i-1];
            end
        end
    end
    if (m_fifo_flush) begin
        m_queue.delete();
    end else begin
        if (!m_issue_stall && m_queue.size() > 0) begin
            void'(m_queue.pop_front());
        end
        if (push_ok) begin
            m_queue.push_back(fetched);
        end
    end
endtask

`endif

/* test/tb_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_top
    import inst_pkg::*, pipe_pkg::*;
();

    localparam int queue_depth  = 8;
    localparam int len_free     = 200;
    localparam int len_hold     = queue_depth + 4;
    localparam int len_drain    = 30;
    localparam int len_branch   = 300;
    localparam int len_exc      = 300;
    localparam int len_stall    = 600;
    localparam int cycle_limit  = 3 + len_free + len_hold + len_drain + len_branch
                                + len_exc + len_stall + 100;

    logic                clk = 1'b0;
    logic                reset;
    logic                fetch_valid;
    logic [pc_width-1:0] fetch_pc;
    opcode_e             fetch_opcode;
    hazard_req_t         req;
    inst_token_t         wb_token;
    logic                pc_stall;
    logic                fifo_flush;

    integer seed = 32'he465;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    `include "tb_pipe_model.svh"

    pipe_top #(
        .queue_depth (queue_depth)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_opcode (fetch_opcode),
        .req          (req),
        .wb_token     (wb_token),
        .pc_stall     (pc_stall),
        .fifo_flush   (fifo_flush)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ========================================================================
    // helpers
    // ========================================================================

    task automatic check_value(input string name, input logic [35:0] got,
                               input logic [35:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic one_in(input int n);
        return ($unsigned($random(seed)) % n) == 0;
    endfunction

    // called 2 ns after an edge; checks mid-cycle and steps the model on the edge.
    task automatic run_cycle(input hazard_req_t r, input logic fv);
        logic [2:0] op_bits;
        op_bits      = 3'($unsigned($random(seed)) % 5);
        req          = r;
        fetch_valid  = fv;
        fetch_pc     = $random(seed);
        fetch_opcode = opcode_e'(op_bits);
        @(negedge clk);
        model_comb();
        check_value("pc_stall", pc_stall, m_pc_stall);
        check_value("fifo_flush", fifo_flush, m_fifo_flush);
        check_value("wb_token.valid", wb_token.valid, m_stage[5].valid);
        if (m_stage[5].valid) begin
            check_value("wb_token.pc", wb_token.pc, m_stage[5].pc);
            check_value("wb_token.opcode", wb_token.opcode, m_stage[5].opcode);
        end
        @(posedge clk);
        model_clock();
        #2;
    endtask

    task automatic report_test(input string name, input int start);
        $display("test %s finished with %0d errors", name, errors - start);
    endtask

    task automatic random_phase(input string name, input int id, input int len);
        hazard_req_t r;
        int          start;
        start = errors;
        repeat (len) begin
            r = '0;
            case (id)
                3: begin
                    r.b_ctrl_flush_req = one_in(6);
                    r.with_delay_slot  = one_in(2);
                    r.forwardc_req     = one_in(8);
                    r.forwardp_req     = one_in(8);
                end
                4: begin
                    r.exception_flush = one_in(12);
                    r.mem_refetch     = one_in(12);
                    r.exc_stall_req   = one_in(4);
                end
                5: begin
                    r.lsu1_tlb_stall_req = one_in(6);
                    r.i_cache_stall_req  = one_in(8);
                    r.d_cache_stall_req  = one_in(8);
                    r.fifo_stall_req     = one_in(2);
                end
                default: ;
            endcase
            run_cycle(r, !one_in(4));
        end
        report_test(name, start);
    endtask

    // issue held by a data cache miss while fetch keeps pushing.
    task automatic backpressure_test();
        hazard_req_t r;
        int          start;
        start = errors;
        r = '0;
        r.d_cache_stall_req = 1'b1;
        repeat (len_hold) begin
            run_cycle(r, 1'b1);
        end
        check_value("pc_stall", pc_stall, 1'b1);
        r = '0;
        repeat (len_drain) begin
            run_cycle(r, 1'b0);
        end
        report_test("fetch_backpressure", start);
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_pc     = '0;
        fetch_opcode = op_nop;
        req          = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        random_phase("free_flow", 1, len_free);
        backpressure_test();
        random_phase("branch_forward", 3, len_branch);
        random_phase("exception_refetch", 4, len_exc);
        random_phase("tlb_cache_stall", 5, len_stall);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_top
    import inst_pkg::*, pipe_pkg::*;
#(
    parameter int queue_depth = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                fetch_valid,
    input  logic [pc_width-1:0] fetch_pc,
    input  opcode_e             fetch_opcode,
    input  hazard_req_t         req,
    output inst_token_t         wb_token,
    output logic                pc_stall,
    output logic                fifo_flush
);

    // ========================================================================
    // controller
    // ========================================================================

    hazard_req_t ctrl_req;
    pipe_ctl_t   ctl;
    logic        queue_full;

    // fetch stall comes from the queue, not from outside.
    always_comb begin
        ctrl_req                = req;
        ctrl_req.fifo_stall_req = queue_full;
    end

    pipe_ctrl u_pipe_ctrl (
        .req (ctrl_req),
        .ctl (ctl)
    );

    assign pc_stall   = ctl.pc_stall;
    assign fifo_flush = ctl.fifo_flush;

    // ========================================================================
    // fetch queue
    // ========================================================================

    inst_token_t fetch_token;
    inst_token_t head_token;

    assign fetch_token = '{valid: fetch_valid, opcode: fetch_opcode, pc: fetch_pc};

    fetch_queue #(
        .queue_depth (queue_depth)
    ) u_fetch_queue (
        .clk        (clk),
        .reset      (reset),
        .push       (fetch_valid),
        .push_token (fetch_token),
        .pop        (~ctl.issue_stall),
        .flush      (ctl.fifo_flush),
        .head_token (head_token),
        .full       (queue_full)
    );

    // ========================================================================
    // boundary registers
    // ========================================================================

    inst_token_t ii_id2_q;
    inst_token_t id2_ex_q;
    inst_token_t ex_lsu1_q;
    inst_token_t lsu1_lsu2_q;
    inst_token_t mem_wb_q;
    stage_ctl_t  wb_ctl;

    // wb only ever holds.
    assign wb_ctl = '{stall: ctl.wb_stall, flush: 1'b0, exp_flush: 1'b0};

    stage_reg u_ii_id2 (
        .clk   (clk),
        .reset (reset),
        .ctl   (ctl.ii_id2),
        .d     (head_token),
        .q     (ii_id2_q)
    );

    stage_reg u_id2_ex (
        .clk   (clk),
        .reset (reset),
        .ctl   (ctl.id2_ex),
        .d     (ii_id2_q),
        .q     (id2_ex_q)
    );

    stage_reg u_ex_lsu1 (
        .clk   (clk),
        .reset (reset),
        .ctl   (ctl.ex_lsu1),
        .d     (id2_ex_q),
        .q     (ex_lsu1_q)
    );

    stage_reg u_lsu1_lsu2 (
        .clk   (clk),
        .reset (reset),
        .ctl   (ctl.lsu1_lsu2),
        .d     (ex_lsu1_q),
        .q     (lsu1_lsu2_q)
    );

    stage_reg u_mem_wb (
        .clk   (clk),
        .reset (reset),
        .ctl   (ctl.mem_wb),
        .d     (lsu1_lsu2_q),
        .q     (mem_wb_q)
    );

    stage_reg u_wb (
        .clk   (clk),
        .reset (reset),
        .ctl   (wb_ctl),
        .d     (mem_wb_q),
        .q     (wb_token)
    );

endmodule

`default_nettype wire

/* logic/stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_reg
    import inst_pkg::*, pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  stage_ctl_t  ctl,
    input  inst_token_t d,
    output inst_token_t q
);

    logic                valid_q;
    opcode_e             opcode_q;
    logic [pc_width-1:0] pc_q;
    logic                load;

    assign load = ~ctl.exp_flush & ~ctl.flush & ~ctl.stall;

    // exception flush, then flush, then stall.
    always_ff @(posedge clk) begin
        if (reset || ctl.exp_flush) begin
            valid_q <= 1'b0;
        end else if (ctl.flush) begin
            valid_q <= 1'b0;
        end else if (!ctl.stall) begin
            valid_q <= d.valid;
        end
    end

    // payload keeps the last pc on a flush for debug visibility.
    always_ff @(posedge clk) begin
        if (load) begin
            opcode_q <= d.opcode;
            pc_q     <= d.pc;
        end
    end

    assign q = '{valid: valid_q, opcode: opcode_q, pc: pc_q};

endmodule

`default_nettype wire

/* logic/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
    import inst_pkg::*;
#(
    parameter int queue_depth = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        push,
    input  inst_token_t push_token,
    input  logic        pop,
    input  logic        flush,
    output inst_token_t head_token,
    output logic        full
);

    // ========================================================================
    // pointers and occupancy
    // ========================================================================

    localparam int ptr_width = $clog2(queue_depth);
    localparam int cnt_width = ptr_width + 1;

    inst_token_t          mem [queue_depth];
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] wr_ptr;
    logic [cnt_width-1:0] count;

    logic empty;
    logic do_push;
    logic do_pop;

    assign empty = (count == '0);
    assign full  = (count == cnt_width'(queue_depth));

    // flush drops the whole queue and the fetch arriving with it.
    assign do_push = push & ~full & ~flush;
    assign do_pop  = pop & ~empty & ~flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ========================================================================
    // storage
    // ========================================================================

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_token;
        end
    end

    // head is visible in the same cycle; stale slots read as invalid.
    always_comb begin
        head_token       = mem[rd_ptr];
        head_token.valid = ~empty;
    end

endmodule

`default_nettype wire

/* logic/pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl
    import pipe_pkg::*;
(
    input  hazard_req_t req,
    output pipe_ctl_t   ctl
);

    // ========================================================================
    // shared terms
    // ========================================================================

    logic exc_any;
    logic cache_stall;
    logic fwd_stall;
    logic front_stall;
    logic mid_stall;
    logic back_stall;
    logic fifo_flush;

    // exception and memory refetch both wipe the front of the pipe.
    assign exc_any = req.exception_flush | req.mem_refetch;

    assign cache_stall = req.i_cache_stall_req | req.d_cache_stall_req;

    // a pending branch flush kills the dependent instruction anyway.
    assign fwd_stall = (req.forwardc_req | req.forwardp_req) & ~req.b_ctrl_flush_req;

    assign front_stall = cache_stall
                       | fwd_stall
                       | req.exc_stall_req
                       | req.lsu1_tlb_stall_req;

    // ex and lsu boundaries ignore forwarding and keep moving on a tlb miss.
    assign mid_stall = cache_stall | req.exc_stall_req;

    // back end is released once the exception flush has been taken.
    assign back_stall = cache_stall | (req.exc_stall_req & ~exc_any);

    assign fifo_flush = req.b_ctrl_flush_req | exc_any;

    // ========================================================================
    // per-boundary outputs
    // ========================================================================

    always_comb begin
        ctl.pc_stall    = req.fifo_stall_req;
        ctl.fifo_flush  = fifo_flush;
        ctl.issue_stall = front_stall;

        // hold ii when the full queue is being flushed this cycle.
        ctl.ii_id2.stall     = front_stall | (req.fifo_stall_req & fifo_flush);
        ctl.ii_id2.flush     = req.b_ctrl_flush_req;
        ctl.ii_id2.exp_flush = exc_any;

        // forwarding stalls ii, so a bubble goes into ex.
        ctl.id2_ex.stall     = cache_stall | req.exc_stall_req | req.lsu1_tlb_stall_req;
        ctl.id2_ex.flush     = (req.b_ctrl_flush_req & req.with_delay_slot)
                             | req.forwardc_req
                             | req.forwardp_req;
        ctl.id2_ex.exp_flush = exc_any;

        ctl.ex_lsu1.stall     = mid_stall;
        ctl.ex_lsu1.flush     = req.lsu1_tlb_stall_req;
        ctl.ex_lsu1.exp_flush = exc_any;

        ctl.lsu1_lsu2.stall     = mid_stall;
        ctl.lsu1_lsu2.flush     = 1'b0;
        ctl.lsu1_lsu2.exp_flush = exc_any;

        // instructions past lsu2 always retire.
        ctl.mem_wb.stall     = back_stall;
        ctl.mem_wb.flush     = 1'b0;
        ctl.mem_wb.exp_flush = 1'b0;

        ctl.wb_stall = back_stall;
    end

endmodule

`default_nettype wire

/* logic/pipe_pkg.sv */
`default_nettype none

// hazard requests and per-boundary control for the pipeline controller.
package pipe_pkg;

    // ========================================================================
    // hazard requests
    // ========================================================================

    // one level per requester, as seen by the controller.
    typedef struct packed {
        logic i_cache_stall_req;
        logic d_cache_stall_req;
        logic fifo_stall_req;
        logic forwardc_req;
        logic forwardp_req;
        logic b_ctrl_flush_req;
        logic with_delay_slot;
        logic exc_stall_req;
        logic exception_flush;
        logic lsu1_tlb_stall_req;
        logic mem_refetch;
    } hazard_req_t;

    // ========================================================================
    // stage controls
    // ========================================================================

    // exp_flush has priority over flush and flush over stall.
    typedef struct packed {
        logic stall;
        logic flush;
        logic exp_flush;
    } stage_ctl_t;

    typedef struct packed {
        logic       pc_stall;
        logic       fifo_flush;
        logic       issue_stall;
        stage_ctl_t ii_id2;
        stage_ctl_t id2_ex;
        stage_ctl_t ex_lsu1;
        stage_ctl_t lsu1_lsu2;
        stage_ctl_t mem_wb;
        logic       wb_stall;
    } pipe_ctl_t;

endpackage

`default_nettype wire

/* logic/inst_pkg.sv */
`default_nettype none

// instruction tokens carried through the queue and stage registers.
package inst_pkg;

    // ========================================================================
    // basic widths
    // ========================================================================

    parameter int pc_width = 32;

    // ========================================================================
    // opcodes
    // ========================================================================

    // coarse classes only since there is no real decode.
    typedef enum logic [2:0] {
        op_nop    = 3'd0,
        op_alu    = 3'd1,
        op_branch = 3'd2,
        op_load   = 3'd3,
        op_store  = 3'd4
    } opcode_e;

    // ========================================================================
    // token
    // ========================================================================

    // valid marks a live instruction; pc and opcode are payload.
    typedef struct packed {
        logic                valid;
        opcode_e             opcode;
        logic [pc_width-1:0] pc;
    } inst_token_t;

endpackage

`default_nettype wire
